/* hw/trigger_pkg.sv */
// Shared widths, defaults and record types for the multichannel trigger delay unit
// Imported by the design blocks and by the testbench
`default_nettype none

package trigger_pkg;

  // Defaults picked up by the top level when no override is given
  localparam int num_channels_default = 4;
  localparam int timer_bits_default = 8;

  // Width of the free-running cycle counter carried in every event
  localparam int stamp_bits = 32;

  // Fixed field widths of the host write record and the event mask.
  // These stay at 8 bits whatever the channel count or timer width.
  localparam int channel_bits = 8;
  localparam int cfg_delay_bits = 8;
  localparam int mask_bits = 8;

  // One host write qualified by cfg_valid
  // The delay field is cut down to the timer width by the decoder
  typedef struct packed {
    logic [channel_bits-1:0]   channel;
    logic [cfg_delay_bits-1:0] delay;
  } cfg_write_t;

  // One output event qualified by event_valid
  // Mask bits above the channel count always read as zero
  typedef struct packed {
    logic [stamp_bits-1:0] stamp;
    logic [mask_bits-1:0]  fired;
  } delay_event_t;

endpackage

`default_nettype wire

/* hw/delay_config.sv */
// Host configuration decoder holding one delay register per trigger channel
// A strobed write updates the addressed channel at the same clock edge
`timescale 1ns/1ns
`default_nettype none

module delay_config
  import trigger_pkg::*;
#(
  parameter int N_CHANNELS = num_channels_default,
  parameter int TIMER_BITS = timer_bits_default
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  cfg_valid,
  input  cfg_write_t                            cfg,
  output logic [N_CHANNELS-1:0][TIMER_BITS-1:0] delays
);

  // Per-channel write enable
  // An index past the last channel matches no bit, so the write is dropped
  logic [N_CHANNELS-1:0] wr_en;

  // Delay field cut down to the timer width
  logic [TIMER_BITS-1:0] wr_delay;

  always_comb begin
    for (int i = 0; i < N_CHANNELS; i++) begin
      wr_en[i] = cfg_valid && (cfg.channel == channel_bits'(i));
    end
  end

  assign wr_delay = cfg.delay[TIMER_BITS-1:0];

  // Delay registers read zero after reset
  // A write issued in cycle k is visible to the channels from cycle k+1
  always_ff @(posedge clk) begin
    if (reset) begin
      delays <= '0;
    end else begin
      for (int i = 0; i < N_CHANNELS; i++) begin
        if (wr_en[i]) begin
          delays[i] <= wr_delay;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/pulse_delay.sv */
// One retriggerable delay channel
// Emits a single-cycle pulse delay+1 cycles after its latest input pulse
`timescale 1ns/1ns
`default_nettype none

module pulse_delay
  import trigger_pkg::*;
#(
  parameter int TIMER_BITS = timer_bits_default
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [TIMER_BITS-1:0] delay,
  input  logic                  in_pls,
  output logic                  out_pls
);

  // Cycles left before the pending pulse is released
  logic [TIMER_BITS-1:0] timer;

  // Set while a pulse is waiting in the timer
  logic pending;

  logic expired;

  assign expired = (timer == '0);

  // The pulse leaves in the cycle the timer reaches zero.
  // With delay 0 this is the cycle right after the input pulse.
  assign out_pls = pending && expired;

  // A new pulse always wins, which restarts any pulse still waiting
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (in_pls) begin
      pending <= 1'b1;
    end else if (expired) begin
      pending <= 1'b0;
    end
  end

  // Only the delay seen with the input pulse matters; later writes
  // to the delay register leave a pending count alone
  always_ff @(posedge clk) begin
    if (in_pls) begin
      timer <= delay;
    end else if (pending && !expired) begin
      timer <= timer - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/event_stamper.sv */
// Free cycle counter and event builder for the delayed trigger outputs
// Every cycle with output activity produces one strobed record a cycle later
`timescale 1ns/1ns
`default_nettype none

module event_stamper
  import trigger_pkg::*;
#(
  parameter int N_CHANNELS = num_channels_default
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [N_CHANNELS-1:0] fired,
  output logic                  event_valid,
  output delay_event_t          evt
);

  // Cycle number that reads zero in the first cycle after reset goes low
  logic [stamp_bits-1:0] count;

  // Channel mask widened to the fixed event field
  logic [mask_bits-1:0] fired_mask;

  logic any_fired;

  always_comb begin
    fired_mask = '0;
    fired_mask[N_CHANNELS-1:0] = fired;
  end

  assign any_fired = |fired;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // There is no back-pressure, so a record lives for exactly one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      event_valid <= 1'b0;
    end else begin
      event_valid <= any_fired;
    end
  end

  // The record holds the count of the cycle in which the channels fired
  always_ff @(posedge clk) begin
    if (any_fired) begin
      evt <= delay_event_t'{stamp: count, fired: fired_mask};
    end
  end

endmodule

`default_nettype wire

/* hw/trigger_delay_top.sv */
// Top level of the trigger delay unit wiring the config decoder, delay channels and stamper
// N_CHANNELS and TIMER_BITS are set here and passed down to the blocks
`timescale 1ns/1ns
`default_nettype none

module trigger_delay_top
  import trigger_pkg::*;
#(
  parameter int N_CHANNELS = num_channels_default,
  parameter int TIMER_BITS = timer_bits_default
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cfg_valid,
  input  cfg_write_t            cfg,
  input  logic [N_CHANNELS-1:0] in_pls,
  output logic [N_CHANNELS-1:0] out_pls,
  output logic                  event_valid,
  output delay_event_t          evt
);

  // The record fields are 8 bits wide, which bounds both parameters
  if (N_CHANNELS < 1 || N_CHANNELS > mask_bits) begin : g_bad_channels
    $error("N_CHANNELS must lie between 1 and %0d", mask_bits);
  end

  if (TIMER_BITS < 1 || TIMER_BITS > cfg_delay_bits) begin : g_bad_timer
    $error("TIMER_BITS must lie between 1 and %0d", cfg_delay_bits);
  end

  // Current delay of every channel where element i feeds channel i
  logic [N_CHANNELS-1:0][TIMER_BITS-1:0] delays;

  delay_config #(
    .N_CHANNELS(N_CHANNELS),
    .TIMER_BITS(TIMER_BITS)
  ) delay_config_i (
    .clk,
    .reset,
    .cfg_valid,
    .cfg,
    .delays
  );

  for (genvar i = 0; i < N_CHANNELS; i++) begin : g_channel
    pulse_delay #(
      .TIMER_BITS(TIMER_BITS)
    ) pulse_delay_i (
      .clk,
      .reset,
      .delay   (delays[i]),
      .in_pls  (in_pls[i]),
      .out_pls (out_pls[i])
    );
  end

  // The stamper watches the same pulses that leave the unit
  event_stamper #(
    .N_CHANNELS(N_CHANNELS)
  ) event_stamper_i (
    .clk,
    .reset,
    .fired (out_pls),
    .event_valid,
    .evt
  );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
// Free-running clock source for the testbench
// The period is set by the instantiating module
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* dv/trigger_delay_props.sv */
// Timing rules of the trigger delay unit as concurrent assertions
// Bound into every instance of the top level
`timescale 1ns/1ns
`default_nettype none

module trigger_delay_props #(
  parameter int N_CHANNELS = 4
) (
  input logic                  clk,
  input logic                  reset,
  input logic [N_CHANNELS-1:0] out_pls,
  input logic                  event_valid
);

  // An event record always has output activity one cycle before it
  a_event_has_cause: assert property (
    @(posedge clk) disable iff (reset) event_valid |-> $past(out_pls != '0)
  ) else $error("event_valid without output pulses in the previous cycle");

  // Output activity is never lost, since the stamper cannot stall
  a_pulse_gives_event: assert property (
    @(posedge clk) disable iff (reset) (out_pls != '0) |=> event_valid
  ) else $error("output pulses without an event record in the next cycle");

  // Reset discards pending pulses and records
  a_quiet_after_reset: assert property (
    @(posedge clk) $fell(reset) |-> (out_pls == '0) && !event_valid
  ) else $error("outputs active in the first cycle after reset");

endmodule

bind trigger_delay_top trigger_delay_props #(
  .N_CHANNELS(N_CHANNELS)
) trigger_delay_props_i (
  .clk         (clk),
  .reset       (reset),
  .out_pls     (out_pls),
  .event_valid (event_valid)
);

`default_nettype wire

/* dv/trigger_delay_tb.sv */
// Testbench for the trigger delay unit, driven by commands from the stimulus file
// A cycle model predicts out_pls and the event records and compares them every cycle
`timescale 1ns/1ns
`default_nettype none

module trigger_delay_tb
  import trigger_pkg::*;
();

  localparam int n_channels = 4;
  localparam int timer_bits = 8;
  localparam int max_commands = 64;

  logic                  clk;
  logic                  reset;
  logic                  cfg_valid;
  cfg_write_t            cfg;
  logic [n_channels-1:0] in_pls;
  logic [n_channels-1:0] out_pls;
  logic                  event_valid;
  delay_event_t          evt;

  // Each command is c_aa_bb in hex as laid out in the stimulus file
  logic [19:0] commands [max_commands];

  // Model state where cycle_count follows the stamp counter of the DUT
  int                    cycle_count;
  logic [timer_bits-1:0] model_delay [n_channels];
  bit                    model_pending [n_channels];
  int                    model_due [n_channels];
  logic [n_channels-1:0] prev_mask;

  int error_count;
  int check_count;
  int fired_total;
  int watchdog_limit;

  tb_clock #(
    .PERIOD_NS(20)
  ) tb_clock_i (
    .clk(clk)
  );

  trigger_delay_top #(
    .N_CHANNELS(n_channels),
    .TIMER_BITS(timer_bits)
  ) trigger_delay_top_i (
    .clk         (clk),
    .reset       (reset),
    .cfg_valid   (cfg_valid),
    .cfg         (cfg),
    .in_pls      (in_pls),
    .out_pls     (out_pls),
    .event_valid (event_valid),
    .evt         (evt)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("Error: %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Drives one cycle from a rising edge, checks it mid-cycle and advances the model
  task automatic run_cycle(input logic write, input cfg_write_t data,
                           input logic [n_channels-1:0] pulses);
    logic [n_channels-1:0] expected_mask;
    cfg_valid <= write;
    cfg <= data;
    in_pls <= pulses;
    @(negedge clk);
    expected_mask = '0;
    for (int i = 0; i < n_channels; i++) begin
      if (model_pending[i] && model_due[i] == cycle_count) begin
        expected_mask[i] = 1'b1;
      end
    end
    check_value($sformatf("out_pls in cycle %0d", cycle_count), expected_mask, out_pls);
    check_value($sformatf("event_valid in cycle %0d", cycle_count), prev_mask != '0,
                event_valid);
    if (prev_mask != '0) begin
      check_value($sformatf("event stamp in cycle %0d", cycle_count), cycle_count - 1,
                  evt.stamp);
      check_value($sformatf("event mask in cycle %0d", cycle_count), prev_mask, evt.fired);
    end
    fired_total += $countones(out_pls);
    // A pulse takes the delay of its own cycle and a write counts from the next one
    for (int i = 0; i < n_channels; i++) begin
      if (expected_mask[i]) begin
        model_pending[i] = 1'b0;
      end
      if (pulses[i]) begin
        model_pending[i] = 1'b1;
        model_due[i] = cycle_count + model_delay[i] + 1;
      end
    end
    if (write && data.channel < n_channels) begin
      model_delay[data.channel] = data.delay[timer_bits-1:0];
    end
    prev_mask = expected_mask;
    cycle_count++;
    @(posedge clk);
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      run_cycle(1'b0, '0, '0);
    end
  endtask

  initial begin
    int         n_commands;
    int         max_delay;
    int         limit;
    int         expected_total;
    bit         ended;
    logic [3:0] op;
    logic [7:0] arg_a;
    logic [7:0] arg_b;
    cfg_write_t write_data;

    void'($urandom(13965));
    reset = 1'b1;
    cfg_valid = 1'b0;
    cfg = '0;
    in_pls = '0;
    error_count = 0;
    check_count = 0;
    fired_total = 0;
    cycle_count = 0;
    prev_mask = '0;
    expected_total = 0;
    ended = 1'b0;
    for (int i = 0; i < n_channels; i++) begin
      model_delay[i] = '0;
      model_pending[i] = 1'b0;
      model_due[i] = 0;
    end
    for (int i = 0; i < max_commands; i++) begin
      commands[i] = '0;
    end
    $readmemh("dv/trigger_stimulus.txt", commands);

    // Worst case run length allows three extra idle cycles after every pulse
    n_commands = 0;
    max_delay = 0;
    limit = 3 + 50;
    while (n_commands < max_commands && commands[n_commands][19:16] != 4'h0) begin
      op = commands[n_commands][19:16];
      arg_b = commands[n_commands][7:0];
      if (op == 4'h1) begin
        limit += 1;
        if (arg_b > max_delay) begin
          max_delay = arg_b;
        end
      end else if (op == 4'h2) begin
        limit += 4 + arg_b;
      end
      n_commands++;
    end
    limit += max_delay + 3;
    watchdog_limit = limit;
    assert (n_commands > 0) else begin
      error_count++;
      $display("The stimulus file could not be read or holds no commands");
    end

    @(posedge clk);
    repeat (2) begin
      @(negedge clk);
      check_value("out_pls during reset", '0, out_pls);
      check_value("event_valid during reset", '0, event_valid);
      @(posedge clk);
    end
    reset <= 1'b0;

    for (int k = 0; k < n_commands && !ended; k++) begin
      op = commands[k][19:16];
      arg_a = commands[k][15:8];
      arg_b = commands[k][7:0];
      case (op)
        4'h1: begin
          write_data.channel = arg_a;
          write_data.delay = arg_b;
          run_cycle(1'b1, write_data, '0);
        end
        4'h2: begin
          run_cycle(1'b0, '0, arg_a[n_channels-1:0]);
          idle_cycles(arg_b + $urandom_range(3, 0));
        end
        4'h3: begin
          expected_total = {arg_a, arg_b};
          ended = 1'b1;
        end
        default: begin
          error_count++;
          $display("Unknown command %0h in line %0d of the stimulus file", op, k);
        end
      endcase
    end
    assert (ended) else begin
      error_count++;
      $display("The stimulus file ends without its closing command");
    end

    // Let the last pending pulses and their records come out
    idle_cycles(max_delay + 3);
    check_value("output pulse count", expected_total, fired_total);

    $display("Finished with %0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    wait (watchdog_limit > 0);
    repeat (watchdog_limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdog_limit);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/trigger_stimulus.txt */
// Columns c_aa_bb in hex. c=1 write: aa channel, bb delay. c=2 pulse: aa mask, bb gap cycles.
// c=3 end: aabb is the total number of output pulses expected over the run.
1_00_00  // channel 0 delay 0
1_01_03  // channel 1 delay 3
1_02_07  // channel 2 delay 7
1_03_0c  // channel 3 delay 12
2_01_02  // lone pulses, one per channel
2_02_05
2_04_09
2_08_0e
2_0f_10  // all channels at once, outputs spread by delay
1_03_14  // channel 3 delay 20
2_08_02  // retrigger inside the window, first output dropped
2_08_1a
2_04_01  // retrigger on channel 2 with delay 7
2_04_0a
2_08_01  // pending pulse on channel 3 with delay 20
1_03_02  // new delay while pending, old pulse keeps its due cycle
2_01_14  // filler pulse on channel 0 while channel 3 waits
2_08_04  // next pulse on channel 3 uses delay 2
1_04_01  // writes to missing channels change nothing
1_80_01
2_0f_10
1_01_05  // equal delays on channels 1 and 2
1_02_05
2_06_08  // simultaneous outputs in one event
3_00_13  // 19 output pulses in total

/* src.f */
hw/trigger_pkg.sv
hw/delay_config.sv
hw/pulse_delay.sv
hw/event_stamper.sv
hw/trigger_delay_top.sv
dv/tb_clock.sv
dv/trigger_delay_props.sv
dv/trigger_delay_tb.sv
